/* cpuPkg.sv */
// Accumulator CPU shared definitions
package cpuPkg;

  localparam int dataW     = 4;  // A, B, TMP, ALU and OUT
  localparam int addrW     = 4;  // PC, MAR and address field
  localparam int wordW     = 8;  // one memory word
  localparam int memDepth  = 16;
  localparam int stepCount = 6;  // ring steps per instruction

  // opcodes, anything else runs as a no-op
  localparam logic [3:0] opLoadA  = 4'b0111;
  localparam logic [3:0] opStoreA = 4'b0110;
  localparam logic [3:0] opXchg   = 4'b0011;
  localparam logic [3:0] opAdd    = 4'b0001;
  localparam logic [3:0] opSub    = 4'b0010;
  localparam logic [3:0] opAnd    = 4'b1000;
  localparam logic [3:0] opOrB    = 4'b1001;
  localparam logic [3:0] opOut    = 4'b1010;
  localparam logic [3:0] opHalt   = 4'b1111;

  // instruction view, opcode over address
  typedef struct packed {
    logic [wordW-addrW-1:0] op;
    logic [addrW-1:0]       addr;
  } instrView_t;

  // data view, zero pad over value
  typedef struct packed {
    logic [wordW-dataW-1:0] pad;
    logic [dataW-1:0]       value;
  } dataView_t;

  typedef union packed {
    instrView_t instr;
    dataView_t  data;
  } memWord_t;

endpackage

/* programMemory.sv */
// Program and data memory
`timescale 1ns/10ps

module programMemory (
  input  logic                     clk,
  input  logic                     progWrite,
  input  logic [cpuPkg::addrW-1:0] progAddr,
  input  cpuPkg::memWord_t         progData,
  input  logic                     memStoreA,
  input  logic [cpuPkg::addrW-1:0] mar,
  input  logic [cpuPkg::dataW-1:0] aValue,
  output cpuPkg::memWord_t         readWord
);

  cpuPkg::memWord_t mem [cpuPkg::memDepth];
  cpuPkg::memWord_t storeWord;

  // A always goes back as plain data
  always_comb
  begin
    storeWord.data.pad   = '0;
    storeWord.data.value = aValue;
  end

  always_ff @(posedge clk)
  begin
    if (progWrite) // loader wins over a store
    begin
      mem[progAddr] <= progData;
    end
    else if (memStoreA)
    begin
      mem[mar] <= storeWord;
    end
  end

  assign readWord = mem[mar]; // async read at MAR

endmodule

/* fetchUnit.sv */
// Instruction fetch unit
`timescale 1ns/10ps

module fetchUnit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     marFromPc,
  input  logic                     pcInc,
  input  logic                     irLoad,
  input  logic                     marFromIr,
  input  cpuPkg::memWord_t         readWord,
  output logic [3:0]               opcode,
  output logic [cpuPkg::addrW-1:0] mar
);

  logic [cpuPkg::addrW-1:0] pc;
  cpuPkg::memWord_t         ir;

  // program counter, wraps at the top of memory
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      pc <= '0;
    end
    else if (pcInc)
    begin
      pc <= pc + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      mar <= '0;
    end
    else if (marFromPc)
    begin
      mar <= pc; // fetch address
    end
    else if (marFromIr)
    begin
      mar <= ir.instr.addr; // operand address
    end
  end

  // cleared IR decodes as a no-op
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      ir <= '0;
    end
    else if (irLoad)
    begin
      ir <= readWord;
    end
  end

  assign opcode = ir.instr.op;

endmodule

/* controlSequencer.sv */
// Ring counter control sequencer
`timescale 1ns/10ps

module controlSequencer (
  input  logic       clk,
  input  logic       reset,
  input  logic [3:0] opcode,
  output logic       marFromPc,
  output logic       pcInc,
  output logic       irLoad,
  output logic       marFromIr,
  output logic       aFromMem,
  output logic       aFromB,
  output logic       aluCapture,
  output logic       aFromAlu,
  output logic       tmpFromA,
  output logic       tmpFromMem,
  output logic       bFromTmp,
  output logic       bFromOr,
  output logic       memStoreA,
  output logic       outLoad,
  output logic       halted
);

  logic [cpuPkg::stepCount-1:0] step; // one-hot, bit 0 is T1

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      step <= 1;
    end
    else if (!halted)
    begin
      step <= {step[cpuPkg::stepCount-2:0], step[cpuPkg::stepCount-1]};
    end
  end

  // sticky until the next reset
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      halted <= 1'b0;
    end
    else if (step[3] && opcode == cpuPkg::opHalt)
    begin
      halted <= 1'b1;
    end
  end

  always_comb
  begin
    marFromPc  = 1'b0;
    pcInc      = 1'b0;
    irLoad     = 1'b0;
    marFromIr  = 1'b0;
    aFromMem   = 1'b0;
    aFromB     = 1'b0;
    aluCapture = 1'b0;
    aFromAlu   = 1'b0;
    tmpFromA   = 1'b0;
    tmpFromMem = 1'b0;
    bFromTmp   = 1'b0;
    bFromOr    = 1'b0;
    memStoreA  = 1'b0;
    outLoad    = 1'b0;
    if (reset && !halted)
    begin
      marFromPc = step[0]; // fetch, same for every opcode
      pcInc     = step[1];
      irLoad    = step[2];
      case (opcode) // execute steps T4 to T6
        cpuPkg::opLoadA:
        begin
          marFromIr = step[3];
          aFromMem  = step[4];
        end
        cpuPkg::opStoreA:
        begin
          marFromIr = step[3];
          memStoreA = step[4];
        end
        cpuPkg::opXchg:
        begin
          tmpFromA = step[3]; // A through TMP into B
          aFromB   = step[4];
          bFromTmp = step[5];
        end
        cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd:
        begin
          aluCapture = step[3];
          aFromAlu   = step[4];
        end
        cpuPkg::opOrB:
        begin
          marFromIr  = step[3];
          tmpFromMem = step[4];
          bFromOr    = step[5];
        end
        cpuPkg::opOut: outLoad = step[3];
        default: ; // halt and no-op raise nothing here
      endcase
    end
  end

endmodule

/* datapath.sv */
// Register file, ALU and output port
`timescale 1ns/10ps

module datapath (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [3:0]               opcode,
  input  cpuPkg::memWord_t         readWord,
  input  logic                     aFromMem,
  input  logic                     aFromB,
  input  logic                     aFromAlu,
  input  logic                     aluCapture,
  input  logic                     tmpFromA,
  input  logic                     tmpFromMem,
  input  logic                     bFromTmp,
  input  logic                     bFromOr,
  input  logic                     outLoad,
  output logic [cpuPkg::dataW-1:0] aValue,
  output logic [cpuPkg::dataW-1:0] outValue,
  output logic                     outStrobe
);

  logic [cpuPkg::dataW-1:0] aReg;
  logic [cpuPkg::dataW-1:0] bReg;
  logic [cpuPkg::dataW-1:0] tmpReg;
  logic [cpuPkg::dataW-1:0] aluNext;
  logic [cpuPkg::dataW-1:0] aluResult;

  always_comb
  begin
    case (opcode)
      cpuPkg::opSub: aluNext = aReg - bReg; // wraps mod 16
      cpuPkg::opAnd: aluNext = aReg & bReg;
      default:       aluNext = aReg + bReg;
    endcase
  end

  // result held from T4 to T5
  always_ff @(posedge clk)
  begin
    if (aluCapture)
    begin
      aluResult <= aluNext;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      aReg   <= '0;
      bReg   <= '0;
      tmpReg <= '0;
    end
    else
    begin
      if (aFromMem) aReg <= readWord.data.value;
      else if (aFromB) aReg <= bReg;
      else if (aFromAlu) aReg <= aluResult;
      if (tmpFromA) tmpReg <= aReg;
      else if (tmpFromMem) tmpReg <= readWord.data.value;
      if (bFromTmp) bReg <= tmpReg;
      else if (bFromOr) bReg <= bReg | tmpReg;
    end
  end

  // output port, strobe marks a fresh value
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      outValue  <= '0;
      outStrobe <= 1'b0;
    end
    else
    begin
      outStrobe <= outLoad;
      if (outLoad) outValue <= aReg;
    end
  end

  assign aValue = aReg;

endmodule

/* sapCpu.sv */
// Accumulator CPU top level
`timescale 1ns/10ps

module sapCpu (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     progWrite,
  input  logic [cpuPkg::addrW-1:0] progAddr,
  input  cpuPkg::memWord_t         progData,
  output logic [cpuPkg::dataW-1:0] outValue,
  output logic                     outStrobe,
  output logic                     halted
);

  logic marFromPc, pcInc, irLoad, marFromIr;
  logic aFromMem, aFromB, aluCapture, aFromAlu;
  logic tmpFromA, tmpFromMem, bFromTmp, bFromOr;
  logic memStoreA, outLoad;

  logic [3:0]               opcode;
  logic [cpuPkg::addrW-1:0] mar;
  logic [cpuPkg::dataW-1:0] aValue;
  cpuPkg::memWord_t         readWord;

  programMemory memory (
    .clk(clk), .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
    .memStoreA(memStoreA), .mar(mar), .aValue(aValue), .readWord(readWord)
  );

  fetchUnit fetch (
    .clk(clk), .reset(reset), .marFromPc(marFromPc), .pcInc(pcInc),
    .irLoad(irLoad), .marFromIr(marFromIr), .readWord(readWord),
    .opcode(opcode), .mar(mar)
  );

  controlSequencer sequencer (
    .clk(clk), .reset(reset), .opcode(opcode),
    .marFromPc(marFromPc), .pcInc(pcInc), .irLoad(irLoad), .marFromIr(marFromIr),
    .aFromMem(aFromMem), .aFromB(aFromB), .aluCapture(aluCapture), .aFromAlu(aFromAlu),
    .tmpFromA(tmpFromA), .tmpFromMem(tmpFromMem), .bFromTmp(bFromTmp), .bFromOr(bFromOr),
    .memStoreA(memStoreA), .outLoad(outLoad), .halted(halted)
  );

  datapath dp (
    .clk(clk), .reset(reset), .opcode(opcode), .readWord(readWord),
    .aFromMem(aFromMem), .aFromB(aFromB), .aFromAlu(aFromAlu), .aluCapture(aluCapture),
    .tmpFromA(tmpFromA), .tmpFromMem(tmpFromMem), .bFromTmp(bFromTmp), .bFromOr(bFromOr),
    .outLoad(outLoad), .aValue(aValue), .outValue(outValue), .outStrobe(outStrobe)
  );

endmodule

/* cpuChecker_checker.sv */
// Output protocol assertions
`timescale 1ns/10ps

module cpuChecker (
  input logic clk,
  input logic reset,
  input logic outStrobe,
  input logic halted
);

  int assertFails = 0; // summed into the final count

  quietAfterReset: assert property (@(posedge clk) !reset |=> !outStrobe && !halted)
    else
    begin
      $error("outStrobe or halted high after a reset cycle");
      assertFails++;
    end

  strobeOneCycle: assert property (@(posedge clk) disable iff (!reset)
    outStrobe |=> !outStrobe)
    else
    begin
      $error("outStrobe high in two consecutive cycles");
      assertFails++;
    end

  haltSticky: assert property (@(posedge clk) disable iff (!reset) halted |=> halted)
    else
    begin
      $error("halted dropped without a reset");
      assertFails++;
    end

  noStrobeHalted: assert property (@(posedge clk) disable iff (!reset)
    !(outStrobe && halted))
    else
    begin
      $error("outStrobe high while halted");
      assertFails++;
    end

endmodule

bind sapCpu cpuChecker outputChecks (
  .clk(clk), .reset(reset), .outStrobe(outStrobe), .halted(halted)
);

/* cpuTb.sv */
// Accumulator CPU testbench
`timescale 1ns/10ps

module cpuTb;

  localparam int numTests  = 13;
  localparam int waitLimit = cpuPkg::memDepth * cpuPkg::stepCount + 40; // cycles per wait

  logic                     clk;
  logic                     reset;
  logic                     progWrite;
  logic [cpuPkg::addrW-1:0] progAddr;
  cpuPkg::memWord_t         progData;
  logic [cpuPkg::dataW-1:0] outValue;
  logic                     outStrobe;
  logic                     halted;

  cpuPkg::memWord_t prog [cpuPkg::memDepth]; // image for the next load
  integer seed = 32'h8197;
  int errors = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int errorsAtStart = 0;
  int assertFails;

  sapCpu UUT (
    .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
    .progData(progData), .outValue(outValue), .outStrobe(outStrobe), .halted(halted)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic cpuPkg::memWord_t instr(logic [3:0] op, logic [cpuPkg::addrW-1:0] addr);
    cpuPkg::memWord_t w;
    w.instr.op   = op;
    w.instr.addr = addr;
    return w;
  endfunction

  function automatic cpuPkg::memWord_t dataWord(logic [cpuPkg::dataW-1:0] value);
    cpuPkg::memWord_t w;
    w.data.pad   = '0;
    w.data.value = value;
    return w;
  endfunction

  // expected ALU result, 4 bits wide so it wraps mod 16
  function automatic logic [cpuPkg::dataW-1:0] aluModel(logic [3:0] op,
      logic [cpuPkg::dataW-1:0] x, logic [cpuPkg::dataW-1:0] y);
    logic [cpuPkg::dataW-1:0] r;
    case (op)
      cpuPkg::opAdd: r = x + y;
      cpuPkg::opSub: r = x - y;
      cpuPkg::opAnd: r = x & y;
      default:       r = 'x;
    endcase
    return r;
  endfunction

  function automatic logic [cpuPkg::dataW-1:0] randomValue();
    logic [31:0] r;
    r = $random(seed);
    return r[cpuPkg::dataW-1:0];
  endfunction

  task automatic checkData(string name, logic [cpuPkg::dataW-1:0] expected,
      logic [cpuPkg::dataW-1:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic checkFlag(string name, logic expected, logic actual);
    if (actual !== expected)
    begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic clearProgram();
    for (int i = 0; i < cpuPkg::memDepth; i++) prog[i] = '0; // unused words stay zero
  endtask

  // whole image goes in while reset is low
  task automatic loadAndReset();
    @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < cpuPkg::memDepth; i++)
    begin
      @(posedge clk);
      progWrite <= 1'b1;
      progAddr  <= i[cpuPkg::addrW-1:0];
      progData  <= prog[i];
    end
    @(posedge clk);
    progWrite <= 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b1;
  endtask

  // kind 0 strobe, 1 halted, 2 nothing within the limit
  task automatic waitOutput(output int kind);
    kind = 2;
    for (int n = 0; n < waitLimit && kind == 2; n++)
    begin
      @(negedge clk);
      if (outStrobe) kind = 0;
      else if (halted) kind = 1;
    end
  endtask

  task automatic expectOutput(logic [cpuPkg::dataW-1:0] expected);
    int kind;
    waitOutput(kind);
    if (kind == 0) checkData("outValue", expected, outValue);
    else if (kind == 1)
    begin
      $display("CPU halted before the expected output strobe");
      errors++;
    end
    else
    begin
      $display("no output strobe within %0d cycles", waitLimit);
      errors++;
    end
  endtask

  task automatic finishTest(string name);
    testsRun++;
    if (errors > errorsAtStart) testsFailed++;
    $display("%s: %s", name, (errors > errorsAtStart) ? "failed" : "ok");
    errorsAtStart = errors;
  endtask

  task automatic testReset();
    clearProgram(); // all no-ops
    loadAndReset();
    @(negedge clk);
    checkFlag("outStrobe", 1'b0, outStrobe);
    checkFlag("halted", 1'b0, halted);
    checkData("outValue", '0, outValue);
    finishTest("reset state");
  endtask

  task automatic testArith(logic [3:0] op, string opName);
    logic [cpuPkg::dataW-1:0] x;
    logic [cpuPkg::dataW-1:0] y;
    x = randomValue();
    y = randomValue();
    clearProgram();
    prog[0]  = instr(cpuPkg::opLoadA, 15); // y into B first
    prog[1]  = instr(cpuPkg::opXchg, 0);
    prog[2]  = instr(cpuPkg::opLoadA, 14);
    prog[3]  = instr(op, 0);
    prog[4]  = instr(cpuPkg::opOut, 0);
    prog[5]  = instr(cpuPkg::opHalt, 0);
    prog[14] = dataWord(x);
    prog[15] = dataWord(y);
    loadAndReset();
    expectOutput(aluModel(op, x, y));
    finishTest($sformatf("%s x=%h y=%h", opName, x, y));
  endtask

  task automatic testStoreReload();
    logic [cpuPkg::dataW-1:0] x;
    x = randomValue();
    clearProgram();
    prog[0]  = instr(cpuPkg::opLoadA, 14);
    prog[1]  = instr(cpuPkg::opStoreA, 13);
    prog[2]  = instr(cpuPkg::opLoadA, 15);
    prog[3]  = instr(cpuPkg::opLoadA, 13);
    prog[4]  = instr(cpuPkg::opOut, 0);
    prog[5]  = instr(cpuPkg::opHalt, 0);
    prog[13] = dataWord(~x); // overwritten by the store
    prog[14] = dataWord(x);
    prog[15] = dataWord(x + 4'd5);
    loadAndReset();
    expectOutput(x);
    finishTest($sformatf("store and reload x=%h", x));
  endtask

  task automatic testOrB();
    logic [cpuPkg::dataW-1:0] x;
    logic [cpuPkg::dataW-1:0] y;
    x = randomValue();
    y = randomValue();
    clearProgram();
    prog[0]  = instr(cpuPkg::opLoadA, 14);
    prog[1]  = instr(cpuPkg::opXchg, 0);
    prog[2]  = instr(cpuPkg::opOrB, 15);
    prog[3]  = instr(cpuPkg::opXchg, 0);
    prog[4]  = instr(cpuPkg::opOut, 0);
    prog[5]  = instr(cpuPkg::opHalt, 0);
    prog[14] = dataWord(x);
    prog[15] = dataWord(y);
    loadAndReset();
    expectOutput(x | y);
    finishTest($sformatf("or into B x=%h y=%h", x, y));
  endtask

  task automatic testOrder();
    logic [cpuPkg::dataW-1:0] v [3];
    int kind;
    int extra;
    int dataAddr;
    clearProgram();
    for (int i = 0; i < 3; i++)
    begin
      v[i] = randomValue();
      dataAddr = 12 + i;
      prog[2*i]      = instr(cpuPkg::opLoadA, dataAddr[cpuPkg::addrW-1:0]);
      prog[2*i+1]    = instr(cpuPkg::opOut, 0);
      prog[dataAddr] = dataWord(v[i]);
    end
    prog[6] = instr(cpuPkg::opHalt, 0);
    loadAndReset();
    for (int i = 0; i < 3; i++) expectOutput(v[i]);
    waitOutput(kind);
    if (kind != 1)
    begin
      $display("halted did not rise after the last output");
      errors++;
    end
    extra = 0;
    repeat (30)
    begin
      @(negedge clk);
      if (outStrobe) extra++;
    end
    if (extra != 0)
    begin
      $display("%0d output strobes seen after halt", extra);
      errors++;
    end
    checkFlag("halted", 1'b1, halted);
    finishTest("output order and halt");
  endtask

  initial
  begin
    reset     = 1'b0;
    progWrite = 1'b0;
    progAddr  = '0;
    progData  = '0;
    testReset();
    for (int i = 0; i < 3; i++)
    begin
      testArith(cpuPkg::opAdd, "add");
      testArith(cpuPkg::opSub, "sub");
      testArith(cpuPkg::opAnd, "and");
    end
    testStoreReload();
    testOrB();
    testOrder();
    assertFails = UUT.outputChecks.assertFails;
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             testsRun, testsFailed, errors, assertFails);
    if (errors == 0 && assertFails == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // twice the worst case of all tests
  initial
  begin
    #(numTests * waitLimit * 10 * 2);
    $display("watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* project.f */
cpuPkg.sv
programMemory.sv
fetchUnit.sv
controlSequencer.sv
datapath.sv
sapCpu.sv
cpuChecker_checker.sv
cpuTb.sv

/* Bender.yml */
package:
  name: sap_cpu

sources:
  - cpuPkg.sv
  - programMemory.sv
  - fetchUnit.sv
  - controlSequencer.sv
  - datapath.sv
  - sapCpu.sv
  - target: test
    files:
      - cpuChecker_checker.sv
      - cpuTb.sv
